// File: rv_mem_pkg.sv
package rv_mem_pkg;

    localparam int xlen           = 32;
    localparam int mem_words      = 256;
    localparam int mem_addr_width = $clog2(mem_words);
    localparam int fifo_depth     = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);
    // holds 0 to fifo_depth
    localparam int credit_width   = 3;

    // major opcodes
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // load funct3
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // store funct3
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    localparam logic [2:0] funct3_addi = 3'b000;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    // same instruction word, I-type and S-type views
    typedef union packed {
        i_fields_t i_fields;
        s_fields_t s_fields;
    } instr_u;

    typedef struct packed {
        instr_u          instr;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] pc;
    } issue_t;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_pc4 = 2'd1,
        wb_mem = 2'd2
    } wb_ctrl_e;

    typedef struct packed {
        logic [xlen-1:0] alu_out;
        logic [xlen-1:0] pc_4;
        logic [xlen-1:0] mem0_rd_data;
        logic [xlen-1:0] mem3_rd_data;
        logic [1:0]      mem_sel;
        wb_ctrl_e        reg_wr_ctrl;
        logic [2:0]      funct3;
        logic [1:0]      byte_offset;
        logic [4:0]      rd;
        logic            reg_wr_en;
        logic            halt;
    } memwb_t;

    typedef struct packed {
        logic [xlen-1:0] reg_wr_data;
        logic [4:0]      rd;
        logic            reg_wr_en;
        logic            halt;
    } wb_t;

endpackage

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem
    import rv_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      wr_en,
    input  logic [3:0]                byte_en,
    input  logic [mem_addr_width-1:0] addr,
    input  logic [xlen-1:0]           wr_data,
    output logic [xlen-1:0]           rd_data
);

    logic [xlen-1:0] mem [mem_words];

    // bank starts out cleared
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en[lane]) begin
                    mem[addr][8*lane +: 8] <= wr_data[8*lane +: 8];
                end
            end
        end
        // registered read one edge after the address
        rd_data <= mem[addr];
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage
    import rv_mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   issue_valid,
    input  issue_t issue,
    output logic   issue_ready,
    input  logic   credit_return,
    output logic   push,
    output memwb_t push_pkt
);

    logic [credit_width-1:0]   credits;
    logic [credit_width-1:0]   credit_next;
    logic                      accept;
    logic                      is_load;
    logic                      is_store;
    logic                      is_addi;
    logic                      is_jal;
    logic                      is_ebreak;
    logic [xlen-1:0]           imm_i;
    logic [xlen-1:0]           imm_s;
    logic [xlen-1:0]           alu_sum;
    logic [xlen-1:0]           eff_addr;
    logic [1:0]                bank;
    logic [1:0]                byte_offset;
    logic [mem_addr_width-1:0] word_addr;
    logic [3:0]                lane_mask;
    logic [3:0]                byte_en;
    logic [xlen-1:0]           st_data;
    logic [xlen-1:0]           mem0_rd_data;
    logic [xlen-1:0]           mem3_rd_data;
    memwb_t                    dec_pkt;
    memwb_t                    stage_q;
    logic                      stage_valid;

    assign accept = issue_valid && issue_ready;

    // opcode decode through both views of the word
    assign is_load  = issue.instr.i_fields.opcode == op_load;
    assign is_store = issue.instr.s_fields.opcode == op_store;
    assign is_addi  = issue.instr.i_fields.opcode == op_imm &&
                      issue.instr.i_fields.funct3 == funct3_addi;
    assign is_jal   = issue.instr.i_fields.opcode == op_jal;
    // EBREAK is the all-zero system encoding with imm 1
    assign is_ebreak = issue.instr.i_fields.opcode == op_system &&
                       issue.instr.i_fields.imm12 == 12'h001 &&
                       issue.instr.i_fields.funct3 == 3'b000 &&
                       issue.instr.i_fields.rs1 == 5'd0 &&
                       issue.instr.i_fields.rd == 5'd0;

    assign imm_i = {{20{issue.instr.i_fields.imm12[11]}}, issue.instr.i_fields.imm12};
    assign imm_s = {{20{issue.instr.s_fields.imm_hi[6]}}, issue.instr.s_fields.imm_hi,
                    issue.instr.s_fields.imm_lo};

    // the I-type sum is both the ADDI result and the load address
    assign alu_sum     = issue.rs1_val + imm_i;
    assign eff_addr    = is_store ? issue.rs1_val + imm_s : alu_sum;
    assign bank        = eff_addr[31:30];
    assign byte_offset = eff_addr[1:0];
    assign word_addr   = eff_addr[mem_addr_width+1:2];

    always_comb begin
        case (issue.instr.s_fields.funct3)
            f3_sb:   lane_mask = 4'b0001;
            f3_sh:   lane_mask = 4'b0011;
            f3_sw:   lane_mask = 4'b1111;
            default: lane_mask = 4'b0000;
        endcase
    end

    // move store data and lanes up to the byte offset
    assign byte_en = lane_mask << byte_offset;
    assign st_data = issue.rs2_val << {byte_offset, 3'b000};

    data_mem i_bank0 (
        .clk     (clk),
        .wr_en   (accept && is_store && bank == 2'd0),
        .byte_en (byte_en),
        .addr    (word_addr),
        .wr_data (st_data),
        .rd_data (mem0_rd_data)
    );

    data_mem i_bank3 (
        .clk     (clk),
        .wr_en   (accept && is_store && bank == 2'd3),
        .byte_en (byte_en),
        .addr    (word_addr),
        .wr_data (st_data),
        .rd_data (mem3_rd_data)
    );

    always_comb begin
        dec_pkt              = '0;
        dec_pkt.alu_out      = alu_sum;
        dec_pkt.pc_4         = issue.pc + 32'd4;
        dec_pkt.mem_sel      = bank;
        dec_pkt.funct3       = issue.instr.i_fields.funct3;
        dec_pkt.byte_offset  = byte_offset;
        dec_pkt.rd           = issue.instr.i_fields.rd;
        dec_pkt.reg_wr_en    = is_load || is_addi || is_jal;
        dec_pkt.halt         = is_ebreak;
        if (is_load) begin
            dec_pkt.reg_wr_ctrl = wb_mem;
        end else if (is_jal) begin
            dec_pkt.reg_wr_ctrl = wb_pc4;
        end else begin
            dec_pkt.reg_wr_ctrl = wb_alu;
        end
    end

    // one credit out per accept and one back per returned pop
    always_comb begin
        credit_next = credits;
        if (accept) begin
            credit_next = credit_next - 1'b1;
        end
        if (credit_return) begin
            credit_next = credit_next + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits     <= credit_width'(fifo_depth);
            issue_ready <= 1'b0;
            stage_valid <= 1'b0;
        end else begin
            credits     <= credit_next;
            issue_ready <= credit_next != '0;
            stage_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_q <= dec_pkt;
        end
    end

    // read words arrive one edge after acceptance
    always_comb begin
        push_pkt              = stage_q;
        push_pkt.mem0_rd_data = mem0_rd_data;
        push_pkt.mem3_rd_data = mem3_rd_data;
    end

    assign push = stage_valid;

    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credits <= credit_width'(fifo_depth));

    // a credit comes back only after one went out
    a_return_after_spend: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> credits != credit_width'(fifo_depth));

endmodule

// File: memwb_fifo.sv
`timescale 1ns/1ps

module memwb_fifo
    import rv_mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  memwb_t push_pkt,
    input  logic   pop,
    output logic   not_empty,
    output memwb_t head,
    output logic   credit_return
);

    memwb_t                    entries [fifo_depth];
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [credit_width-1:0]   count;

    assign not_empty = count != '0;
    assign head      = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a freed slot goes back to the producer
            credit_return <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_pkt;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> count != credit_width'(fifo_depth));

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> count != '0);

endmodule

// File: write_back.sv
`timescale 1ns/1ps

module write_back
    import rv_mem_pkg::*;
(
    input  memwb_t pkt,
    output wb_t    wb
);

    logic [xlen-1:0] mem_word;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] load_data;

    // banks 1 and 2 are absent and read as zero
    always_comb begin
        case (pkt.mem_sel)
            2'd0:    mem_word = pkt.mem0_rd_data;
            2'd3:    mem_word = pkt.mem3_rd_data;
            default: mem_word = '0;
        endcase
    end

    // addressed byte down to lane 0
    assign lane_data = mem_word >> {pkt.byte_offset, 3'b000};

    always_comb begin
        case (pkt.funct3)
            f3_lw:   load_data = mem_word;
            f3_lh:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            f3_lb:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            f3_lhu:  load_data = {16'd0, lane_data[15:0]};
            f3_lbu:  load_data = {24'd0, lane_data[7:0]};
            default: load_data = '0;
        endcase
    end

    always_comb begin
        wb.rd        = pkt.rd;
        wb.reg_wr_en = pkt.reg_wr_en;
        wb.halt      = pkt.halt;
        case (pkt.reg_wr_ctrl)
            wb_alu:  wb.reg_wr_data = pkt.alu_out;
            wb_pc4:  wb.reg_wr_data = pkt.pc_4;
            wb_mem:  wb.reg_wr_data = load_data;
            default: wb.reg_wr_data = '0;
        endcase
    end

endmodule

// File: wb_stage.sv
`timescale 1ns/1ps

module wb_stage
    import rv_mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   not_empty,
    input  memwb_t head,
    input  logic   wb_stall,
    output logic   pop,
    output wb_t    wb,
    output logic   wb_valid
);

    wb_t wb_next;

    write_back i_write_back (
        .pkt (head),
        .wb  (wb_next)
    );

    // drain one packet per cycle unless held off
    assign pop = not_empty && !wb_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wb <= wb_next;
        end
    end

    // every popped entry was written by the producer
    a_pop_known: assert property (@(posedge clk) disable iff (reset)
        pop |-> !$isunknown(head));

endmodule

// File: rv_mem_wb.sv
`timescale 1ns/1ps

module rv_mem_wb
    import rv_mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   issue_valid,
    input  issue_t issue,
    output logic   issue_ready,
    input  logic   wb_stall,
    output wb_t    wb,
    output logic   wb_valid
);

    logic   credit_return;
    logic   push;
    memwb_t push_pkt;
    logic   pop;
    logic   not_empty;
    memwb_t head;

    mem_stage i_mem_stage (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .credit_return (credit_return),
        .push          (push),
        .push_pkt      (push_pkt)
    );

    memwb_fifo i_memwb_fifo (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_pkt      (push_pkt),
        .pop           (pop),
        .not_empty     (not_empty),
        .head          (head),
        .credit_return (credit_return)
    );

    wb_stage i_wb_stage (
        .clk       (clk),
        .reset     (reset),
        .not_empty (not_empty),
        .head      (head),
        .wb_stall  (wb_stall),
        .pop       (pop),
        .wb        (wb),
        .wb_valid  (wb_valid)
    );

endmodule

// File: tb_rv_mem_wb.sv
`timescale 1ns/1ps

module tb_rv_mem_wb
    import rv_mem_pkg::*;
();

    localparam int clk_period = 100;
    localparam int total_ops  = 52 + 48 + 40 + 3 * fifo_depth + 200;

    logic   clk = 1'b0;
    logic   reset;
    logic   issue_valid;
    issue_t issue;
    logic   issue_ready;
    logic   wb_stall;
    wb_t    wb;
    logic   wb_valid;

    logic [xlen-1:0] bank0_m [mem_words];
    logic [xlen-1:0] bank3_m [mem_words];
    wb_t             exp_q [$];
    wb_t             exp_wb;
    int              credits_m;
    logic            ready_m;
    logic            accepted;
    int              stall_pct;
    int              errors = 0;
    int              checks = 0;
    int              ops = 0;
    int              test_errors;
    int              test_ops;

    rv_mem_wb i_rv_mem_wb (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_stall    (wb_stall),
        .wb          (wb),
        .wb_valid    (wb_valid)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [2:0] load_kind(input int k);
        case (k)
            0:       return f3_lb;
            1:       return f3_lh;
            2:       return f3_lw;
            3:       return f3_lbu;
            default: return f3_lhu;
        endcase
    endfunction

    // word index up to 15 with the offset aligned to the access size
    function automatic logic [31:0] make_addr(input logic [1:0] bank, input logic [2:0] f3);
        logic [1:0] off;
        off = 2'($urandom_range(3)) & 2'(~((1 << f3[1:0]) - 1));
        return {bank, 20'd0, 8'($urandom_range(15)), off};
    endfunction

    function automatic issue_t make_load(input logic [2:0] f3, input logic [31:0] addr);
        issue_t      op;
        logic [11:0] imm;
        imm        = 12'($urandom);
        op.instr   = {imm, 5'($urandom), f3, 5'($urandom), op_load};
        op.rs1_val = addr - sext12(imm);
        op.rs2_val = $urandom;
        op.pc      = $urandom & 32'hffff_fffc;
        return op;
    endfunction

    function automatic issue_t make_store(input logic [2:0] f3, input logic [31:0] addr);
        issue_t      op;
        logic [11:0] imm;
        imm        = 12'($urandom);
        op.instr   = {imm[11:5], 5'($urandom), 5'($urandom), f3, imm[4:0], op_store};
        op.rs1_val = addr - sext12(imm);
        op.rs2_val = $urandom;
        op.pc      = $urandom & 32'hffff_fffc;
        return op;
    endfunction

    // kind 0 is ADDI, 1 is JAL and 2 is EBREAK
    function automatic issue_t make_alu_op(input int kind);
        issue_t op;
        op.rs1_val = $urandom;
        op.rs2_val = $urandom;
        op.pc      = $urandom & 32'hffff_fffc;
        if (kind == 0) begin
            op.instr = {12'($urandom), 5'($urandom), funct3_addi, 5'($urandom), op_imm};
        end else if (kind == 1) begin
            op.instr = {20'($urandom), 5'($urandom), op_jal};
        end else begin
            op.instr = 32'h0010_0073;
        end
        return op;
    endfunction

    function automatic issue_t random_op();
        int          kind;
        logic [2:0]  f3;
        kind = $urandom_range(9);
        if (kind <= 2) begin
            f3 = load_kind($urandom_range(4));
            return make_load(f3, make_addr(2'($urandom), f3));
        end else if (kind <= 4) begin
            f3 = 3'($urandom_range(2));
            return make_store(f3, make_addr(2'($urandom), f3));
        end
        return make_alu_op(kind <= 6 ? 0 : (kind <= 8 ? 1 : 2));
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        case (addr[31:30])
            2'd0:    return bank0_m[addr[mem_addr_width+1:2]];
            2'd3:    return bank3_m[addr[mem_addr_width+1:2]];
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] off,
                                               input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            f3_lb:   return {{24{b[7]}}, b};
            f3_lbu:  return {24'd0, b};
            f3_lh:   return {{16{h[15]}}, h};
            f3_lhu:  return {16'd0, h};
            f3_lw:   return word;
            default: return 32'd0;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input logic [2:0] f3,
                               input logic [31:0] data);
        int                        nbytes;
        logic [mem_addr_width-1:0] idx;
        nbytes = 1 << f3[1:0];
        idx    = addr[mem_addr_width+1:2];
        for (int i = 0; i < nbytes; i++) begin
            if (addr[31:30] == 2'd0) begin
                bank0_m[idx][8*(addr[1:0]+i) +: 8] = data[8*i +: 8];
            end else if (addr[31:30] == 2'd3) begin
                bank3_m[idx][8*(addr[1:0]+i) +: 8] = data[8*i +: 8];
            end
        end
    endtask

    // expected write-back straight from the RV32I semantics
    task automatic model_accept(input issue_t op);
        logic [31:0] w;
        logic [31:0] addr;
        wb_t         exp;
        w   = op.instr;
        exp = '0;
        exp.rd = w[11:7];
        case (w[6:0])
            op_load: begin
                addr              = op.rs1_val + sext12(w[31:20]);
                exp.reg_wr_en     = 1'b1;
                exp.reg_wr_data   = load_value(model_read(addr), addr[1:0], w[14:12]);
            end
            op_store: begin
                addr = op.rs1_val + sext12({w[31:25], w[11:7]});
                model_store(addr, w[14:12], op.rs2_val);
            end
            op_imm: begin
                exp.reg_wr_en   = 1'b1;
                exp.reg_wr_data = op.rs1_val + sext12(w[31:20]);
            end
            op_jal: begin
                exp.reg_wr_en   = 1'b1;
                exp.reg_wr_data = op.pc + 32'd4;
            end
            default: exp.halt = (w == 32'h0010_0073);
        endcase
        exp_q.push_back(exp);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got.reg_wr_en !== exp.reg_wr_en) begin
            report_mismatch("wb.reg_wr_en", got.reg_wr_en, exp.reg_wr_en);
        end
        if (got.halt !== exp.halt) begin
            report_mismatch("wb.halt", got.halt, exp.halt);
        end
        if (got.rd !== exp.rd) begin
            report_mismatch("wb.rd", got.rd, exp.rd);
        end
        // data only means something on a register write
        if (exp.reg_wr_en && got.reg_wr_data !== exp.reg_wr_data) begin
            report_mismatch("wb.reg_wr_data", got.reg_wr_data, exp.reg_wr_data);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            report_mismatch("issue_ready", got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            credits_m = fifo_depth;
            ready_m   = 1'b0;
        end else begin
            check_ready(issue_ready, ready_m);
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    $display("write-back at %0t with no operation outstanding", $time);
                    errors++;
                end else begin
                    exp_wb = exp_q.pop_front();
                    check_wb(wb, exp_wb);
                end
            end
            accepted = issue_valid && issue_ready;
            if (accepted) begin
                model_accept(issue);
                ops++;
            end
            credits_m = credits_m - int'(accepted) + int'(wb_valid);
            ready_m   = credits_m != 0;
        end
    end

    // holds the op until a ready edge takes it and redraws the stall every cycle
    task automatic send(input issue_t op);
        logic taken;
        taken       = 1'b0;
        issue_valid = 1'b1;
        issue       = op;
        while (!taken) begin
            wb_stall = $urandom_range(99) < stall_pct;
            taken    = issue_ready;
            @(negedge clk);
        end
        issue_valid = 1'b0;
        if ($urandom_range(3) == 0) begin
            @(negedge clk);
        end
    endtask

    task automatic drain();
        issue_valid = 1'b0;
        wb_stall    = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic start_test();
        test_errors = errors;
        test_ops    = ops;
    endtask

    task automatic end_test(input int num, input string name);
        drain();
        $display("test %0d %s: %0d operations, %0d errors", num, name, ops - test_ops,
                 errors - test_errors);
    endtask

    initial begin
        repeat (total_ops * 20 + 8) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", total_ops * 20 + 8);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [2:0]  f3;
        issue_t      op;
        int          n;
        logic        ready_seen;
        void'($urandom(32'hcff0515b));
        for (int i = 0; i < mem_words; i++) begin
            bank0_m[i] = '0;
            bank3_m[i] = '0;
        end
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        wb_stall    = 1'b0;
        stall_pct   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // store then load for every load kind and lane in banks 0 and 3
        start_test();
        stall_pct = 20;
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < 5; k++) begin
                f3 = load_kind(k);
                for (int off = 0; off < 4; off += 1 << f3[1:0]) begin
                    addr = {b == 0 ? 2'd0 : 2'd3, 20'd0, 8'($urandom_range(15)), 2'(off)};
                    send(make_store({1'b0, f3[1:0]}, addr));
                    send(make_load(f3, addr));
                end
            end
        end
        end_test(1, "store/load lanes");

        // absent banks and then the same word in bank 0
        start_test();
        stall_pct = 0;
        for (int r = 0; r < 16; r++) begin
            f3   = load_kind($urandom_range(4));
            addr = make_addr(2'd1 + 2'(r % 2), f3);
            send(make_store(3'($urandom_range(2)), {addr[31:2], 2'b00}));
            send(make_load(f3, addr));
            send(make_load(f3_lw, {2'd0, addr[29:2], 2'b00}));
        end
        end_test(2, "absent banks");

        start_test();
        stall_pct = 30;
        for (int i = 0; i < 40; i++) begin
            if ($urandom_range(3) == 0) begin
                f3 = 3'($urandom_range(2));
                send(make_store(f3, make_addr(2'($urandom), f3)));
            end else begin
                send(make_alu_op($urandom_range(2)));
            end
        end
        end_test(3, "addi/jal/store/ebreak");

        // full stall until credits run out
        start_test();
        n           = 0;
        wb_stall    = 1'b1;
        op          = random_op();
        issue_valid = 1'b1;
        for (int c = 0; c < 4 * fifo_depth; c++) begin
            issue      = op;
            ready_seen = issue_ready;
            @(negedge clk);
            if (ready_seen) begin
                n++;
                op = random_op();
            end
        end
        issue_valid = 1'b0;
        if (n != fifo_depth) begin
            $display("stall test accepted %0d operations while stalled, expected %0d",
                     n, fifo_depth);
            errors++;
        end
        stall_pct = 50;
        for (int i = 0; i < 2 * fifo_depth; i++) begin
            send(random_op());
        end
        end_test(4, "long stall");

        start_test();
        stall_pct = $urandom_range(60, 10);
        for (int i = 0; i < 200; i++) begin
            send(random_op());
        end
        end_test(5, "random traffic");

        $display("%0d checks, %0d errors, %0d operations", checks, errors, ops);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: compile.f
rv_mem_pkg.sv
data_mem.sv
mem_stage.sv
memwb_fifo.sv
write_back.sv
wb_stage.sv
rv_mem_wb.sv
tb_rv_mem_wb.sv
